/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // release just after the second edge, clear of the flops' sampling point
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* bench/geom_unit_tb.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module geom_unit_tb;
    import geom_pkg::*;

    localparam int  PW         = 2 * `COORD_W;
    localparam int  MAX_CYCLES = 4000;  // ~85 commands at under 20 cycles each, plus slot sweeps
    localparam int  MAX_BUSY   = 64;
    localparam real PI         = 3.14159265358979;

    logic                  clk, rst_n, go, busy, obj_mem_full;
    logic [3:0]            gmt_op, gmt_code;
    logic [1:0]            obj_type;
    logic [7:0]            obj_color;
    logic [`OBJ_NUM_W-1:0] obj_num, look_num, last_obj_num;
    coord_t                v [8];
    obj_word_t             look_obj;

    obj_word_t model_mem [`OBJ_CNT];    // expected store contents
    int        n_used;
    int        seed = 32'hb0e;
    int        cycle_cnt = 0;

    clk_gen i_clk_gen (.clk, .rst_n);

    geom_unit i_geom_unit (
        .clk, .rst_n, .go, .gmt_op, .gmt_code, .obj_type, .obj_color, .obj_num,
        .v0 (v[0]), .v1 (v[1]), .v2 (v[2]), .v3 (v[3]),
        .v4 (v[4]), .v5 (v[5]), .v6 (v[6]), .v7 (v[7]),
        .busy, .obj_mem_full, .last_obj_num, .look_num, .look_obj
    );

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run went past the limit of %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_equal(input string name, input logic [`OBJ_W-1:0] got,
                               input logic [`OBJ_W-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %0h expected %0h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int wrap16(input longint val);
        return {{16{val[15]}}, val[15:0]};
    endfunction

    // round to Q1.15, +1.0 clamps to the largest code
    function automatic int q15(input real val);
        int r;
        r = $rtoi(val * 32768.0 + ((val < 0.0) ? -0.5 : 0.5));
        if (r > 32767) r = 32767;
        if (r < -32768) r = -32768;
        return r;
    endfunction

    // expected object after one transform command
    function automatic obj_word_t ref_transform(input obj_word_t w, input logic [3:0] op,
                                                input logic [3:0] code, input int off);
        obj_word_t r;
        int        t, cx, cy, nx, ny, num, sh;
        int        x [4];
        int        y [4];
        longint    c1, c2, c3, c4;
        real       a;
        logic      about_cen;
        r = w;
        t = w[`OBJ_W-1 -: 2];
        about_cen = (op == OP_SCALE) ||
                    ((op == OP_ROT_LEFT || op == OP_ROT_RIGHT) && code[3]);
        if (about_cen && t == OBJ_TRI) return w;    // no divide by three
        for (int i = 0; i < 4; i++) begin
            x[i] = $signed(w[PW*i +: `COORD_W]);
            y[i] = $signed(w[PW*i + `COORD_W +: `COORD_W]);
        end
        cx = 0;
        cy = 0;
        if (about_cen) begin
            case (t)
                0: begin
                    cx = x[0];
                    cy = y[0];
                end
                1: begin
                    cx = wrap16((x[0] + x[1]) >>> 1);
                    cy = wrap16((y[0] + y[1]) >>> 1);
                end
                default: begin
                    cx = wrap16((x[0] + x[1] + x[2] + x[3]) >>> 2);
                    cy = wrap16((y[0] + y[1] + y[2] + y[3]) >>> 2);
                end
            endcase
            for (int i = 0; i < 4; i++) begin
                x[i] = wrap16(x[i] - cx);
                y[i] = wrap16(y[i] - cy);
            end
        end
        a = code[2:0] * 45.0 * PI / 180.0;
        if (op == OP_ROT_RIGHT) a = -a;     // clockwise
        c1 = q15($cos(a));
        c3 = q15($sin(a));
        c2 = q15(-$sin(a));
        c4 = c1;
        case (code[1:0])
            2'd0: begin
                num = 1;
                sh  = 1;
            end
            2'd1: begin
                num = 3;
                sh  = 2;
            end
            2'd2: begin
                num = 3;
                sh  = 1;
            end
            default: begin
                num = 2;
                sh  = 0;
            end
        endcase
        for (int i = 0; i <= t; i++) begin
            nx = x[i];
            ny = y[i];
            if (op == OP_TRANS_ALL || (op == OP_TRANS_ONE && i == code[3:2])) begin
                if (code[0]) nx = wrap16(x[i] + off);
                if (code[1]) ny = wrap16(y[i] + off);
            end else if (op == OP_SCALE) begin
                nx = wrap16((x[i] * num) >>> sh);
                ny = wrap16((y[i] * num) >>> sh);
            end else if (op == OP_ROT_LEFT || op == OP_ROT_RIGHT) begin
                nx = wrap16((x[i] * c1 + y[i] * c2) >>> `ROT_FRAC);
                ny = wrap16((x[i] * c3 + y[i] * c4) >>> `ROT_FRAC);
            end
            if (about_cen) begin
                nx = wrap16(nx + cx);
                ny = wrap16(ny + cy);
            end
            r[PW*i +: `COORD_W]            = nx[15:0];
            r[PW*i + `COORD_W +: `COORD_W] = ny[15:0];
        end
        return r;
    endfunction

    task automatic wait_busy_low(output int cyc);
        cyc = 0;
        while (busy) begin
            cyc++;
            if (cyc > MAX_BUSY) begin
                $display("busy stayed high for more than %0d cycles", MAX_BUSY);
                abort_run();
            end
            @(posedge clk);
            #1;
        end
    endtask

    // one go pulse, then wait for the end of the command
    task automatic send_cmd(input logic [3:0] op, input logic [3:0] code,
                            input logic [`OBJ_NUM_W-1:0] num, output int busy_cyc);
        wait_busy_low(busy_cyc);
        @(posedge clk);
        #1;
        gmt_op   = op;
        gmt_code = code;
        obj_num  = num;
        go       = 1'b1;
        @(posedge clk);
        #1;
        go = 1'b0;
        wait_busy_low(busy_cyc);
    endtask

    task automatic check_slot(input int num);
        @(posedge clk);
        #1;
        look_num = num[`OBJ_NUM_W-1:0];
        #1;
        check_equal($sformatf("look_obj[%0d]", num), look_obj, model_mem[num]);
    endtask

    task automatic check_all_slots();
        for (int i = 0; i < n_used; i++) check_slot(i);
    endtask

    task automatic create_obj(input logic [1:0] t, input logic [7:0] color);
        obj_word_t exp;
        int        cyc;
        int        prev;
        exp = '0;
        @(posedge clk);
        #1;
        for (int i = 0; i < 8; i++) v[i] = $random(seed) % 4000;
        for (int i = 0; i <= t; i++) begin
            exp[PW*i +: `COORD_W]            = v[2*i];
            exp[PW*i + `COORD_W +: `COORD_W] = v[2*i+1];
        end
        exp[PW*`NUM_PTS +: 8] = color;
        exp[`OBJ_W-1 -: 2]    = t;
        obj_type  = t;
        obj_color = color;
        prev      = last_obj_num;
        send_cmd(OP_CREATE, 4'h0, '0, cyc);
        if (n_used < `OBJ_CNT) begin
            model_mem[n_used] = exp;
            check_equal("last_obj_num", last_obj_num, n_used);
            check_slot(n_used);
            n_used++;
        end else begin
            check_equal("busy cycles", cyc, 1);     // refused create
            check_equal("last_obj_num", last_obj_num, prev);
            check_all_slots();
        end
        check_equal("obj_mem_full", obj_mem_full, n_used == `OBJ_CNT);
    endtask

    task automatic run_transform(input logic [3:0] op, input logic [3:0] code,
                                 input logic [`OBJ_NUM_W-1:0] num);
        int cyc;
        int off;
        off  = $random(seed) % 1000;
        @(posedge clk);
        #1;
        v[0] = coord_t'(off);       // translate offset
        send_cmd(op, code, num, cyc);
        model_mem[num] = ref_transform(model_mem[num], op, code, off);
        check_slot(num);
    endtask

    task automatic test_reset_state();
        check_equal("busy", busy, 1'b0);
        check_equal("obj_mem_full", obj_mem_full, 1'b0);
    endtask

    task automatic test_create();
        for (int t = 0; t < 4; t++) create_obj(2'(t), 8'($random(seed)));
    endtask

    task automatic test_translate();
        for (int s = 0; s < 4; s++) begin
            for (int c = 1; c < 4; c++) run_transform(OP_TRANS_ALL, 4'(c), 5'(s));
        end
        for (int p = 0; p < 4; p++) run_transform(OP_TRANS_ONE, {2'(p), 2'(p % 3 + 1)}, 5'd3);
        run_transform(OP_TRANS_ONE, 4'b0111, 5'd1);
        run_transform(OP_TRANS_ONE, 4'b1011, 5'd0);    // point 2 of a point, nothing moves
    endtask

    task automatic test_scale();
        for (int f = 0; f < 4; f++) begin
            run_transform(OP_SCALE, 4'(f), 5'd1);
            run_transform(OP_SCALE, 4'(f), 5'd3);
        end
        run_transform(OP_SCALE, 4'd3, 5'd2);   // triangle refused
        run_transform(OP_SCALE, 4'd0, 5'd0);
    endtask

    task automatic test_rotate();
        logic [3:0] code;
        for (int k = 0; k < 4; k++) begin
            code = {k[1], k[0] ? 3'd1 : 3'd2};     // 90 or 45 degrees, origin or centroid
            run_transform(OP_ROT_LEFT, code, 5'd3);
            run_transform(OP_ROT_RIGHT, code, 5'd3);
            run_transform(OP_ROT_LEFT, code, 5'd1);
            run_transform(OP_ROT_RIGHT, code, 5'd1);
        end
        run_transform(OP_ROT_LEFT, 4'd10, 5'd2);
        run_transform(OP_ROT_RIGHT, 4'd2, 5'd2);
    endtask

    task automatic test_undefined_op();
        logic [3:0] ops [4];
        int         cyc;
        ops = '{4'h1, 4'h2, 4'h8, 4'hf};
        for (int i = 0; i < 4; i++) begin
            send_cmd(ops[i], 4'hf, 5'd3, cyc);
            check_equal("busy cycles", cyc, 0);
            @(posedge clk);
            #1;
            check_equal("busy", busy, 1'b0);
        end
        check_all_slots();
    endtask

    task automatic test_fill();
        while (n_used < `OBJ_CNT) create_obj(2'($random(seed)), 8'($random(seed)));
        create_obj(2'd3, 8'h5a);   // store full, nothing written
    endtask

    initial begin
        go        = 1'b0;
        gmt_op    = '0;
        gmt_code  = '0;
        obj_type  = '0;
        obj_color = '0;
        obj_num   = '0;
        look_num  = '0;
        for (int i = 0; i < 8; i++) v[i] = '0;
        n_used = 0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        test_reset_state();
        test_create();
        test_translate();
        test_scale();
        test_rotate();
        test_undefined_op();
        test_fill();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/geom_pkg.sv
source/rot_coeff_rom.sv
source/obj_store.sv
source/shape_regs.sv
source/point_transform.sv
source/geom_sequencer.sv
source/geom_unit.sv
bench/clk_gen.sv
bench/geom_unit_tb.sv

/* source/geom_defines.svh */
`ifndef GEOM_DEFINES_SVH
`define GEOM_DEFINES_SVH

`define COORD_W   16    // signed coordinate width
`define NUM_PTS   4     // points per object
`define OBJ_W     144   // packed object word, 4 points + colour + type
`define OBJ_CNT   32    // object store depth
`define OBJ_NUM_W 5     // object index width
`define ROT_FRAC  15    // Q1.15 rotation coefficients

`endif

/* source/geom_pkg.sv */
`include "geom_defines.svh"

package geom_pkg;

    // command opcodes, codes not listed here are ignored
    typedef enum logic [3:0] {
        OP_CREATE    = 4'h0,
        OP_TRANS_ONE = 4'h3,
        OP_TRANS_ALL = 4'h4,
        OP_SCALE     = 4'h5,
        OP_ROT_LEFT  = 4'h6,
        OP_ROT_RIGHT = 4'h7
    } gmt_op_e;

    // point count is type + 1
    typedef enum logic [1:0] {
        OBJ_POINT = 2'd0,
        OBJ_LINE  = 2'd1,
        OBJ_TRI   = 2'd2,
        OBJ_QUAD  = 2'd3
    } obj_type_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_READ,
        ST_LOAD,
        ST_CENTRE,
        ST_WAIT_COEFF,
        ST_ISSUE,
        ST_DRAIN,
        ST_WRITE,
        ST_END
    } seq_state_e;

    typedef logic signed [`COORD_W-1:0] coord_t;
    typedef logic [`OBJ_W-1:0] obj_word_t;

endpackage

/* source/geom_sequencer.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module geom_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    go,
    input  logic [3:0]              gmt_op,
    input  logic [3:0]              gmt_code,
    input  logic [1:0]              obj_type_in,
    input  logic [7:0]              obj_color,
    input  logic [`OBJ_NUM_W-1:0]   obj_num,
    input  geom_pkg::coord_t        v0, v1, v2, v3, v4, v5, v6, v7,
    input  logic                    store_full,
    input  logic [`OBJ_NUM_W-1:0]   alloc_num,
    input  geom_pkg::obj_type_e     work_type,
    input  logic                    res_vld,
    input  geom_pkg::coord_t        rom_cos,
    input  geom_pkg::coord_t        rom_sin,
    output logic                    busy,
    output logic [`OBJ_NUM_W-1:0]   last_obj_num,
    output logic                    store_alloc,
    output logic                    store_wr,
    output logic [`OBJ_NUM_W-1:0]   store_wr_num,
    output logic                    wr_sel,         // 1 = create word
    output geom_pkg::obj_word_t     crt_obj,
    output logic                    store_rd,
    output logic [`OBJ_NUM_W-1:0]   store_rd_num,
    output logic                    load_obj,
    output logic                    calc_cen,
    output logic                    add_cen,
    output logic                    pt_vld,
    output logic [1:0]              pt_idx,
    output geom_pkg::coord_t        c11, c12, c13, c21, c22, c23,
    output logic [3:0]              shift_amt,
    output logic [3:0]              rom_addr
);
    import geom_pkg::*;

    seq_state_e state, nxt;
    logic [1:0] cnt;            // point being issued
    logic [2:0] pending;        // points inside the pipeline
    logic       rot_op, cen_op, trans_op;
    logic [2*`NUM_PTS*`COORD_W-1:0] v_flat;

    // negate a Q1.15 value, with +-1.0 mapped onto the saturated codes
    function automatic coord_t neg_q15(input coord_t c);
        if (c == 16'sh7fff) return 16'sh8000;
        if (c == 16'sh8000) return 16'sh7fff;
        return -c;
    endfunction

    assign rot_op   = (gmt_op == OP_ROT_LEFT) || (gmt_op == OP_ROT_RIGHT);
    assign trans_op = (gmt_op == OP_TRANS_ONE) || (gmt_op == OP_TRANS_ALL);
    assign cen_op   = (gmt_op == OP_SCALE) || (rot_op && gmt_code[3]);

    always_comb begin
        nxt = state;
        case (state)
            ST_IDLE: begin
                if (go) begin
                    if (gmt_op == OP_CREATE) begin
                        nxt = store_full ? ST_END : ST_WRITE;
                    end else if (trans_op || rot_op || gmt_op == OP_SCALE) begin
                        nxt = ST_READ;
                    end
                end
            end
            ST_READ:       nxt = ST_LOAD;
            ST_LOAD:       nxt = cen_op ? ST_CENTRE : (rot_op ? ST_WAIT_COEFF : ST_ISSUE);
            ST_CENTRE: begin
                if (work_type == OBJ_TRI) begin
                    nxt = ST_END;               // refused, object left as is
                end else begin
                    nxt = rot_op ? ST_WAIT_COEFF : ST_ISSUE;
                end
            end
            ST_WAIT_COEFF: nxt = ST_ISSUE;      // rom output lands here
            ST_ISSUE: begin
                if (cnt == work_type) begin
                    nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (pending == 3'd0 || (pending == 3'd1 && res_vld)) begin
                    nxt = ST_WRITE;
                end
            end
            default:       nxt = ST_IDLE;       // WRITE and END
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            cnt          <= '0;
            pending      <= '0;
            rom_addr     <= '0;
            last_obj_num <= '0;
        end else begin
            state   <= nxt;
            pending <= pending + {2'b0, pt_vld} - {2'b0, res_vld};
            if (state == ST_ISSUE) begin
                cnt <= (cnt == work_type) ? 2'd0 : cnt + 2'd1;
            end
            if (state == ST_LOAD) begin
                rom_addr <= {gmt_op == OP_ROT_RIGHT, gmt_code[2:0]};
            end
            if (store_alloc) begin
                last_obj_num <= alloc_num;
            end
        end
    end

    assign busy         = (state != ST_IDLE);
    assign store_rd     = (state == ST_READ);
    assign store_rd_num = obj_num;
    assign load_obj     = (state == ST_LOAD);
    assign calc_cen     = (state == ST_CENTRE) && (work_type != OBJ_TRI);
    assign add_cen      = cen_op;
    assign store_wr     = (state == ST_WRITE);
    assign wr_sel       = (gmt_op == OP_CREATE);
    assign store_alloc  = store_wr && wr_sel;
    assign store_wr_num = wr_sel ? alloc_num : obj_num;

    // translate-one skips every point but the selected one
    assign pt_idx = cnt;
    assign pt_vld = (state == ST_ISSUE) &&
                    ((gmt_op != OP_TRANS_ONE) || (cnt == gmt_code[3:2]));

    assign v_flat = {v7, v6, v5, v4, v3, v2, v1, v0};

    always_comb begin
        crt_obj = '0;
        for (int i = 0; i < `NUM_PTS; i++) begin
            if (i <= obj_type_in) begin
                crt_obj[2*`COORD_W*i +: 2*`COORD_W] = v_flat[2*`COORD_W*i +: 2*`COORD_W];
            end
        end
        crt_obj[2*`COORD_W*`NUM_PTS +: 8] = obj_color;
        crt_obj[`OBJ_W-1 -: 2]            = obj_type_in;
    end

    // affine coefficients, identity by default
    always_comb begin
        c11       = 16'sd1;
        c12       = '0;
        c13       = '0;
        c21       = '0;
        c22       = 16'sd1;
        c23       = '0;
        shift_amt = '0;
        if (trans_op) begin
            c13 = gmt_code[0] ? v0 : '0;
            c23 = gmt_code[1] ? v0 : '0;
        end else if (gmt_op == OP_SCALE) begin
            case (gmt_code[1:0])
                2'd0: begin             // 1/2
                    c11       = 16'sd1;
                    shift_amt = 4'd1;
                end
                2'd1: begin             // 3/4
                    c11       = 16'sd3;
                    shift_amt = 4'd2;
                end
                2'd2: begin             // 3/2
                    c11       = 16'sd3;
                    shift_amt = 4'd1;
                end
                default: c11 = 16'sd2;
            endcase
            c22 = c11;
        end else if (rot_op) begin
            c11       = rom_cos;
            c12       = neg_q15(rom_sin);
            c21       = rom_sin;
            c22       = rom_cos;
            shift_amt = 4'(`ROT_FRAC);
        end
    end

endmodule

/* source/geom_unit.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module geom_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    go,
    input  logic [3:0]              gmt_op,
    input  logic [3:0]              gmt_code,
    input  logic [1:0]              obj_type,
    input  logic [7:0]              obj_color,
    input  logic [`OBJ_NUM_W-1:0]   obj_num,
    input  geom_pkg::coord_t        v0, v1, v2, v3, v4, v5, v6, v7,
    output logic                    busy,
    output logic                    obj_mem_full,
    output logic [`OBJ_NUM_W-1:0]   last_obj_num,
    input  logic [`OBJ_NUM_W-1:0]   look_num,
    output geom_pkg::obj_word_t     look_obj
);
    import geom_pkg::*;

    logic                  store_alloc, store_wr, store_rd, wr_sel;
    logic [`OBJ_NUM_W-1:0] store_wr_num, store_rd_num, alloc_num;
    obj_word_t             crt_obj, wb_obj, wr_obj, rd_obj;
    logic                  load_obj, calc_cen, add_cen;
    obj_type_e             work_type;
    logic                  pt_vld, res_vld;
    logic [1:0]            pt_idx, res_idx;
    coord_t                pt_x, pt_y, res_x, res_y;
    coord_t                c11, c12, c13, c21, c22, c23;
    coord_t                rom_cos, rom_sin;
    logic [3:0]            shift_amt, rom_addr;

    geom_sequencer i_geom_sequencer (
        .clk, .rst_n, .go, .gmt_op, .gmt_code,
        .obj_type_in (obj_type),
        .obj_color, .obj_num,
        .v0, .v1, .v2, .v3, .v4, .v5, .v6, .v7,
        .store_full  (obj_mem_full),
        .alloc_num, .work_type, .res_vld, .rom_cos, .rom_sin,
        .busy, .last_obj_num, .store_alloc, .store_wr, .store_wr_num,
        .wr_sel, .crt_obj, .store_rd, .store_rd_num,
        .load_obj, .calc_cen, .add_cen, .pt_vld, .pt_idx,
        .c11, .c12, .c13, .c21, .c22, .c23, .shift_amt, .rom_addr
    );

    assign wr_obj = wr_sel ? crt_obj : wb_obj;    // create word or transformed copy

    obj_store i_obj_store (
        .clk, .rst_n,
        .alloc    (store_alloc),
        .wr       (store_wr),
        .wr_num   (store_wr_num),
        .wr_obj,
        .rd       (store_rd),
        .rd_num   (store_rd_num),
        .look_num,
        .alloc_num,
        .full     (obj_mem_full),
        .rd_obj,
        .look_obj
    );

    shape_regs i_shape_regs (
        .clk, .rst_n, .load_obj,
        .obj_in   (rd_obj),
        .calc_cen,
        .pt_sel   (pt_idx),
        .res_vld, .res_idx, .res_x, .res_y, .add_cen,
        .pt_x, .pt_y,
        .obj_type (work_type),
        .wb_obj
    );

    rot_coeff_rom i_rot_coeff_rom (
        .clk,
        .addr  (rom_addr),
        .c_cos (rom_cos),
        .c_sin (rom_sin)
    );

    point_transform i_point_transform (
        .clk, .rst_n, .pt_vld, .pt_idx,
        .in_x (pt_x),
        .in_y (pt_y),
        .c11, .c12, .c13, .c21, .c22, .c23, .shift_amt,
        .res_vld, .res_idx, .res_x, .res_y
    );

endmodule

/* source/obj_store.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module obj_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    alloc,      // write claims a free slot
    input  logic                    wr,
    input  logic [`OBJ_NUM_W-1:0]   wr_num,
    input  geom_pkg::obj_word_t     wr_obj,
    input  logic                    rd,
    input  logic [`OBJ_NUM_W-1:0]   rd_num,
    input  logic [`OBJ_NUM_W-1:0]   look_num,
    output logic [`OBJ_NUM_W-1:0]   alloc_num,
    output logic                    full,
    output geom_pkg::obj_word_t     rd_obj,
    output geom_pkg::obj_word_t     look_obj
);
    import geom_pkg::*;

    obj_word_t          mem [`OBJ_CNT];
    logic [`OBJ_CNT-1:0] used;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
        end else if (wr && alloc) begin
            used[wr_num] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_num] <= wr_obj;
        end
        if (rd) begin
            rd_obj <= mem[rd_num];      // one cycle read latency
        end
    end

    // lowest free slot wins
    always_comb begin
        alloc_num = '0;
        for (int i = `OBJ_CNT-1; i >= 0; i--) begin
            if (!used[i]) begin
                alloc_num = `OBJ_NUM_W'(i);
            end
        end
    end

    assign full     = &used;
    assign look_obj = mem[look_num];    // display / cpu peek

endmodule

/* source/point_transform.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module point_transform (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pt_vld,
    input  logic [1:0]        pt_idx,
    input  geom_pkg::coord_t  in_x,
    input  geom_pkg::coord_t  in_y,
    input  geom_pkg::coord_t  c11,
    input  geom_pkg::coord_t  c12,
    input  geom_pkg::coord_t  c13,      // x offset
    input  geom_pkg::coord_t  c21,
    input  geom_pkg::coord_t  c22,
    input  geom_pkg::coord_t  c23,      // y offset
    input  logic [3:0]        shift_amt,
    output logic              res_vld,
    output logic [1:0]        res_idx,
    output geom_pkg::coord_t  res_x,
    output geom_pkg::coord_t  res_y
);
    import geom_pkg::*;

    logic signed [2*`COORD_W-1:0] p11, p12, p21, p22;
    logic signed [2*`COORD_W:0]   sum_x, sum_y, sh_x, sh_y;
    logic                         s1_vld;
    logic [1:0]                   s1_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld  <= 1'b0;
            res_vld <= 1'b0;
        end else begin
            s1_vld  <= pt_vld;
            res_vld <= s1_vld;
        end
    end

    always_comb begin
        sum_x = p11 + p12;
        sum_y = p21 + p22;
        sh_x  = sum_x >>> shift_amt;    // scale divide or Q1.15 back to integer
        sh_y  = sum_y >>> shift_amt;
    end

    always_ff @(posedge clk) begin
        if (pt_vld) begin               // stage 1, products
            p11    <= in_x * c11;
            p12    <= in_y * c12;
            p21    <= in_x * c21;
            p22    <= in_y * c22;
            s1_idx <= pt_idx;
        end
        if (s1_vld) begin               // stage 2, sum / shift / offset
            res_x   <= sh_x[`COORD_W-1:0] + c13;
            res_y   <= sh_y[`COORD_W-1:0] + c23;
            res_idx <= s1_idx;
        end
    end

endmodule

/* source/rot_coeff_rom.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module rot_coeff_rom (
    input  logic              clk,
    input  logic [3:0]        addr,   // {right, angle / 45}
    output geom_pkg::coord_t  c_cos,
    output geom_pkg::coord_t  c_sin
);
    import geom_pkg::*;

    logic [2*`COORD_W-1:0] entry;   // {cos, sin}

    // Q1.15, +1.0 saturates to 7fff, -1.0 is exact
    // right-hand entries hold the negative angle
    always_comb begin
        case (addr)
            4'd0:    entry = {16'h7fff, 16'h0000};
            4'd1:    entry = {16'sd23170, 16'sd23170};
            4'd2:    entry = {16'h0000, 16'h7fff};
            4'd3:    entry = {-16'sd23170, 16'sd23170};
            4'd4:    entry = {16'h8000, 16'h0000};
            4'd5:    entry = {-16'sd23170, -16'sd23170};
            4'd6:    entry = {16'h0000, 16'h8000};
            4'd7:    entry = {16'sd23170, -16'sd23170};
            4'd8:    entry = {16'h7fff, 16'h0000};
            4'd9:    entry = {16'sd23170, -16'sd23170};
            4'd10:   entry = {16'h0000, 16'h8000};
            4'd11:   entry = {-16'sd23170, -16'sd23170};
            4'd12:   entry = {16'h8000, 16'h0000};
            4'd13:   entry = {-16'sd23170, 16'sd23170};
            4'd14:   entry = {16'h0000, 16'h7fff};
            default: entry = {16'sd23170, 16'sd23170};
        endcase
    end

    always_ff @(posedge clk) begin
        c_cos <= entry[2*`COORD_W-1:`COORD_W];
        c_sin <= entry[`COORD_W-1:0];
    end

endmodule

/* source/shape_regs.sv */
`timescale 1ns/1ps
`include "geom_defines.svh"

module shape_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_obj,
    input  geom_pkg::obj_word_t  obj_in,
    input  logic                 calc_cen,
    input  logic [1:0]           pt_sel,
    input  logic                 res_vld,
    input  logic [1:0]           res_idx,
    input  geom_pkg::coord_t     res_x,
    input  geom_pkg::coord_t     res_y,
    input  logic                 add_cen,
    output geom_pkg::coord_t     pt_x,
    output geom_pkg::coord_t     pt_y,
    output geom_pkg::obj_type_e  obj_type,
    output geom_pkg::obj_word_t  wb_obj
);
    import geom_pkg::*;

    localparam int PW = 2 * `COORD_W;   // bits per packed point

    coord_t px [`NUM_PTS];
    coord_t py [`NUM_PTS];
    coord_t cx, cy;                     // stored centroid
    logic [7:0] color;
    logic signed [`COORD_W+1:0] sum_x, sum_y;
    coord_t cen_x, cen_y;

    // triangles never get here, they would need a divide by 3
    always_comb begin
        sum_x = (obj_type == OBJ_QUAD) ? px[0] + px[1] + px[2] + px[3] : px[0] + px[1];
        sum_y = (obj_type == OBJ_QUAD) ? py[0] + py[1] + py[2] + py[3] : py[0] + py[1];
        case (obj_type)
            OBJ_LINE: begin
                cen_x = sum_x[`COORD_W:1];
                cen_y = sum_y[`COORD_W:1];
            end
            OBJ_QUAD: begin
                cen_x = sum_x[`COORD_W+1:2];
                cen_y = sum_y[`COORD_W+1:2];
            end
            default: begin
                cen_x = px[0];
                cen_y = py[0];
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_type <= OBJ_POINT;
        end else if (load_obj) begin
            obj_type <= obj_type_e'(obj_in[`OBJ_W-1 -: 2]);
        end
    end

    always_ff @(posedge clk) begin
        if (load_obj) begin
            for (int i = 0; i < `NUM_PTS; i++) begin
                px[i] <= obj_in[PW*i +: `COORD_W];
                py[i] <= obj_in[PW*i + `COORD_W +: `COORD_W];
            end
            color <= obj_in[PW*`NUM_PTS +: 8];
        end else if (calc_cen) begin
            cx <= cen_x;
            cy <= cen_y;
            for (int i = 0; i < `NUM_PTS; i++) begin
                px[i] <= px[i] - cen_x;     // points now relative to centroid
                py[i] <= py[i] - cen_y;
            end
        end else if (res_vld) begin
            px[res_idx] <= res_x;
            py[res_idx] <= res_y;
        end
    end

    assign pt_x = px[pt_sel];
    assign pt_y = py[pt_sel];

    // unused points go back as zero
    always_comb begin
        wb_obj = '0;
        for (int i = 0; i < `NUM_PTS; i++) begin
            if (i <= obj_type) begin
                wb_obj[PW*i +: `COORD_W]            = add_cen ? px[i] + cx : px[i];
                wb_obj[PW*i + `COORD_W +: `COORD_W] = add_cen ? py[i] + cy : py[i];
            end
        end
        wb_obj[PW*`NUM_PTS +: 8] = color;
        wb_obj[`OBJ_W-1 -: 2]    = obj_type;
    end

endmodule
